/* hw/camera.sv */
`timescale 1ns/1ps
// Camera front end top level
// Decoder, crop and metering on the pixel path, AXI4-Lite registers for control
module camera #(
    parameter int DIM_WIDTH = 12
) (
    input logic mipi_byte_clock,
    input logic mipi_byte_reset_n,

    input logic rx_sp_en_i,
    input logic rx_lp_av_en_i,
    input logic [5:0] rx_dt_i,
    input logic [15:0] rx_wc_i,
    input logic rx_payload_en_i,
    input camera_pkg::pixel_t rx_payload_i,

    input logic [4:0] s_axi_awaddr_i,
    input logic s_axi_awvalid_i,
    output logic s_axi_awready_o,
    input logic [31:0] s_axi_wdata_i,
    input logic [3:0] s_axi_wstrb_i,
    input logic s_axi_wvalid_i,
    output logic s_axi_wready_o,
    output logic [1:0] s_axi_bresp_o,
    output logic s_axi_bvalid_o,
    input logic s_axi_bready_i,
    input logic [4:0] s_axi_araddr_i,
    input logic s_axi_arvalid_i,
    output logic s_axi_arready_o,
    output logic [31:0] s_axi_rdata_o,
    output logic [1:0] s_axi_rresp_o,
    output logic s_axi_rvalid_o,
    input logic s_axi_rready_i
);

logic pix_frame_valid, pix_line_valid;
camera_pkg::pixel_t pix_data;
logic crop_frame_valid, crop_line_valid;
camera_pkg::pixel_t crop_data;
logic [camera_pkg::SUM_WIDTH-1:0] meter_sum;
logic [2*DIM_WIDTH-1:0] meter_count;
camera_pkg::pixel_t meter_peak;
logic meter_ready;
logic [DIM_WIDTH-1:0] x_start, x_end, y_start, y_end;

csi2_packet_decoder decoder (
    .mipi_byte_clock(mipi_byte_clock),
    .mipi_byte_reset_n(mipi_byte_reset_n),
    .rx_sp_en_i(rx_sp_en_i),
    .rx_lp_av_en_i(rx_lp_av_en_i),
    .rx_dt_i(rx_dt_i),
    .rx_wc_i(rx_wc_i),
    .rx_payload_en_i(rx_payload_en_i),
    .rx_payload_i(rx_payload_i),
    .frame_valid_o(pix_frame_valid),
    .line_valid_o(pix_line_valid),
    .pixel_o(pix_data)
);

crop #(.DIM_WIDTH(DIM_WIDTH)) window_crop (
    .mipi_byte_clock(mipi_byte_clock),
    .mipi_byte_reset_n(mipi_byte_reset_n),
    .frame_valid_i(pix_frame_valid),
    .line_valid_i(pix_line_valid),
    .pixel_i(pix_data),
    .x_start_i(x_start),
    .x_end_i(x_end),
    .y_start_i(y_start),
    .y_end_i(y_end),
    .frame_valid_o(crop_frame_valid),
    .line_valid_o(crop_line_valid),
    .pixel_o(crop_data)
);

metering #(.DIM_WIDTH(DIM_WIDTH)) meter (
    .mipi_byte_clock(mipi_byte_clock),
    .mipi_byte_reset_n(mipi_byte_reset_n),
    .frame_valid_i(crop_frame_valid),
    .line_valid_i(crop_line_valid),
    .pixel_i(crop_data),
    .sum_o(meter_sum),
    .count_o(meter_count),
    .peak_o(meter_peak),
    .ready_o(meter_ready)
);

camera_registers #(.DIM_WIDTH(DIM_WIDTH)) registers (
    .mipi_byte_clock(mipi_byte_clock),
    .mipi_byte_reset_n(mipi_byte_reset_n),
    .s_axi_awaddr_i(s_axi_awaddr_i),
    .s_axi_awvalid_i(s_axi_awvalid_i),
    .s_axi_awready_o(s_axi_awready_o),
    .s_axi_wdata_i(s_axi_wdata_i),
    .s_axi_wstrb_i(s_axi_wstrb_i),
    .s_axi_wvalid_i(s_axi_wvalid_i),
    .s_axi_wready_o(s_axi_wready_o),
    .s_axi_bresp_o(s_axi_bresp_o),
    .s_axi_bvalid_o(s_axi_bvalid_o),
    .s_axi_bready_i(s_axi_bready_i),
    .s_axi_araddr_i(s_axi_araddr_i),
    .s_axi_arvalid_i(s_axi_arvalid_i),
    .s_axi_arready_o(s_axi_arready_o),
    .s_axi_rdata_o(s_axi_rdata_o),
    .s_axi_rresp_o(s_axi_rresp_o),
    .s_axi_rvalid_o(s_axi_rvalid_o),
    .s_axi_rready_i(s_axi_rready_i),
    .sum_i(meter_sum),
    .count_i(meter_count),
    .peak_i(meter_peak),
    .ready_i(meter_ready),
    .x_start_o(x_start),
    .x_end_o(x_end),
    .y_start_o(y_start),
    .y_end_o(y_end)
);

endmodule

/* hw/camera_pkg.sv */
// Camera front end shared definitions
// Pixel type, CSI-2 data types, register map and AXI response codes
package camera_pkg;

    // One RAW8 pixel
    typedef logic [7:0] pixel_t;

    // CSI-2 data type codes
    localparam logic [5:0] DT_FRAME_START = 6'h00;
    localparam logic [5:0] DT_FRAME_END   = 6'h01;
    localparam logic [5:0] DT_RAW8        = 6'h2A;

    // Register byte offsets
    localparam logic [4:0] REG_X_START = 5'h00;
    localparam logic [4:0] REG_X_END   = 5'h04;
    localparam logic [4:0] REG_Y_START = 5'h08;
    localparam logic [4:0] REG_Y_END   = 5'h0C;
    localparam logic [4:0] REG_SUM     = 5'h10; // Read only from here on
    localparam logic [4:0] REG_COUNT   = 5'h14;
    localparam logic [4:0] REG_PEAK    = 5'h18;
    localparam logic [4:0] REG_FRAMES  = 5'h1C;

    // AXI responses
    localparam logic [1:0] RESP_OKAY   = 2'b00;
    localparam logic [1:0] RESP_SLVERR = 2'b10;

    // Brightness sum width, enough for 8 bit pixels over a 1M pixel window
    localparam int SUM_WIDTH = 28;

endpackage

/* hw/camera_registers.sv */
`timescale 1ns/1ps
// Camera register block
// AXI4-Lite slave for the crop window, metering results and the frame count
module camera_registers #(
    parameter int DIM_WIDTH = 12
) (
    input logic mipi_byte_clock,
    input logic mipi_byte_reset_n,

    input logic [4:0] s_axi_awaddr_i,
    input logic s_axi_awvalid_i,
    output logic s_axi_awready_o,
    input logic [31:0] s_axi_wdata_i,
    input logic [3:0] s_axi_wstrb_i,
    input logic s_axi_wvalid_i,
    output logic s_axi_wready_o,
    output logic [1:0] s_axi_bresp_o,
    output logic s_axi_bvalid_o,
    input logic s_axi_bready_i,
    input logic [4:0] s_axi_araddr_i,
    input logic s_axi_arvalid_i,
    output logic s_axi_arready_o,
    output logic [31:0] s_axi_rdata_o,
    output logic [1:0] s_axi_rresp_o,
    output logic s_axi_rvalid_o,
    input logic s_axi_rready_i,

    input logic [camera_pkg::SUM_WIDTH-1:0] sum_i,
    input logic [2*DIM_WIDTH-1:0] count_i,
    input camera_pkg::pixel_t peak_i,
    input logic ready_i,

    output logic [DIM_WIDTH-1:0] x_start_o,
    output logic [DIM_WIDTH-1:0] x_end_o,
    output logic [DIM_WIDTH-1:0] y_start_o,
    output logic [DIM_WIDTH-1:0] y_end_o
);

logic [31:0] frame_count;
logic [31:0] wmask;
logic write_en;
logic read_en;

// Apply byte strobes to an old register value
function automatic logic [DIM_WIDTH-1:0] merge(input logic [DIM_WIDTH-1:0] old_val);
    logic [31:0] merged;
    merged = (32'(old_val) & ~wmask) | (s_axi_wdata_i & wmask);
    return merged[DIM_WIDTH-1:0];
endfunction

always_comb begin
    for (int i = 0; i < 4; i++) begin
        wmask[8*i +: 8] = {8{s_axi_wstrb_i[i]}};
    end
    write_en = s_axi_awvalid_i && s_axi_wvalid_i && !s_axi_bvalid_o;
    read_en = s_axi_arvalid_i && !s_axi_rvalid_o;
    s_axi_awready_o = write_en; // Address and data taken together
    s_axi_wready_o = write_en;
    s_axi_arready_o = !s_axi_rvalid_o;
end

always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        s_axi_bvalid_o <= 1'b0;
        s_axi_bresp_o <= camera_pkg::RESP_OKAY;
        x_start_o <= '0;
        x_end_o <= '1;
        y_start_o <= '0;
        y_end_o <= '1;
    end else begin
        if (s_axi_bvalid_o && s_axi_bready_i) begin
            s_axi_bvalid_o <= 1'b0;
        end
        if (write_en) begin
            s_axi_bvalid_o <= 1'b1;
            s_axi_bresp_o <= camera_pkg::RESP_OKAY;
            case (s_axi_awaddr_i)
                camera_pkg::REG_X_START: x_start_o <= merge(x_start_o);
                camera_pkg::REG_X_END: x_end_o <= merge(x_end_o);
                camera_pkg::REG_Y_START: y_start_o <= merge(y_start_o);
                camera_pkg::REG_Y_END: y_end_o <= merge(y_end_o);
                camera_pkg::REG_SUM, camera_pkg::REG_COUNT,
                camera_pkg::REG_PEAK, camera_pkg::REG_FRAMES: ; // Read only, ignored
                default: s_axi_bresp_o <= camera_pkg::RESP_SLVERR;
            endcase
        end
    end
end

// Read data is held until rready
always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        s_axi_rvalid_o <= 1'b0;
        s_axi_rdata_o <= '0;
        s_axi_rresp_o <= camera_pkg::RESP_OKAY;
    end else if (read_en) begin
        s_axi_rvalid_o <= 1'b1;
        s_axi_rresp_o <= camera_pkg::RESP_OKAY;
        case (s_axi_araddr_i)
            camera_pkg::REG_X_START: s_axi_rdata_o <= 32'(x_start_o);
            camera_pkg::REG_X_END: s_axi_rdata_o <= 32'(x_end_o);
            camera_pkg::REG_Y_START: s_axi_rdata_o <= 32'(y_start_o);
            camera_pkg::REG_Y_END: s_axi_rdata_o <= 32'(y_end_o);
            camera_pkg::REG_SUM: s_axi_rdata_o <= 32'(sum_i); // Held by metering
            camera_pkg::REG_COUNT: s_axi_rdata_o <= 32'(count_i);
            camera_pkg::REG_PEAK: s_axi_rdata_o <= 32'(peak_i);
            camera_pkg::REG_FRAMES: s_axi_rdata_o <= frame_count;
            default: begin
                s_axi_rdata_o <= '0;
                s_axi_rresp_o <= camera_pkg::RESP_SLVERR;
            end
        endcase
    end else if (s_axi_rready_i) begin
        s_axi_rvalid_o <= 1'b0;
    end
end

always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        frame_count <= '0;
    end else if (ready_i) begin
        frame_count <= frame_count + 32'd1;
    end
end

read_data_held: assert property (
    @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
    s_axi_rvalid_o && !s_axi_rready_i |=> s_axi_rvalid_o && $stable(s_axi_rdata_o)
) else $error("Read data changed while stalled");

endmodule

/* hw/crop.sv */
`timescale 1ns/1ps
// Crop block
// Passes only pixels inside the programmed window, window is latched per frame
module crop #(
    parameter int DIM_WIDTH = 12
) (
    input logic mipi_byte_clock,
    input logic mipi_byte_reset_n,

    input logic frame_valid_i,
    input logic line_valid_i,
    input camera_pkg::pixel_t pixel_i,

    input logic [DIM_WIDTH-1:0] x_start_i,
    input logic [DIM_WIDTH-1:0] x_end_i,
    input logic [DIM_WIDTH-1:0] y_start_i,
    input logic [DIM_WIDTH-1:0] y_end_i,

    output logic frame_valid_o,
    output logic line_valid_o,
    output camera_pkg::pixel_t pixel_o
);

logic [DIM_WIDTH-1:0] x_count;
logic [DIM_WIDTH-1:0] y_count;
logic [DIM_WIDTH-1:0] x_start_q, x_end_q, y_start_q, y_end_q;
logic line_valid_q;
logic in_window;

always_comb begin
    in_window = (x_count >= x_start_q) && (x_count < x_end_q) &&
                (y_count >= y_start_q) && (y_count < y_end_q);
end

always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        frame_valid_o <= 1'b0;
        line_valid_o <= 1'b0;
        line_valid_q <= 1'b0;
        x_count <= '0;
        y_count <= '0;
        x_start_q <= '0;
        x_end_q <= '1;
        y_start_q <= '0;
        y_end_q <= '1;
    end else begin
        frame_valid_o <= frame_valid_i; // Also serves as the delayed frame valid
        line_valid_o <= line_valid_i && in_window;
        line_valid_q <= line_valid_i;

        // Shadow copy of the window at the rising frame valid
        if (frame_valid_i && !frame_valid_o) begin
            x_start_q <= x_start_i;
            x_end_q <= x_end_i;
            y_start_q <= y_start_i;
            y_end_q <= y_end_i;
        end

        x_count <= line_valid_i ? x_count + 1'b1 : '0;

        if (!frame_valid_i) begin
            y_count <= '0;
        end else if (line_valid_q && !line_valid_i) begin
            y_count <= y_count + 1'b1; // Next line
        end
    end
end

always_ff @(posedge mipi_byte_clock) begin
    pixel_o <= pixel_i;
end

// Upstream must keep lines inside frames for the window counters to hold
line_in_frame: assert property (
    @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
    line_valid_o |-> frame_valid_o
) else $error("Cropped line valid outside frame valid");

endmodule

/* hw/csi2_packet_decoder.sv */
`timescale 1ns/1ps
// CSI-2 packet decoder
// Turns receiver short and long packets into RAW8 pixels with frame and line valid
module csi2_packet_decoder (
    input logic mipi_byte_clock,
    input logic mipi_byte_reset_n,

    input logic rx_sp_en_i,
    input logic rx_lp_av_en_i,
    input logic [5:0] rx_dt_i,
    input logic [15:0] rx_wc_i,
    input logic rx_payload_en_i,
    input camera_pkg::pixel_t rx_payload_i,

    output logic frame_valid_o,
    output logic line_valid_o,
    output camera_pkg::pixel_t pixel_o
);

logic [15:0] bytes_left;
logic take_byte;
logic frame_start;
logic frame_end;

always_comb begin
    frame_start = rx_sp_en_i && (rx_dt_i == camera_pkg::DT_FRAME_START);
    frame_end = rx_sp_en_i && (rx_dt_i == camera_pkg::DT_FRAME_END);
    take_byte = rx_payload_en_i && (bytes_left != 16'd0); // Only bytes of a RAW8 line
end

always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        frame_valid_o <= 1'b0;
        line_valid_o <= 1'b0;
        bytes_left <= 16'd0;
    end else begin
        if (frame_start) begin
            frame_valid_o <= 1'b1;
        end else if (frame_end) begin
            frame_valid_o <= 1'b0;
        end

        // Load the word count at the packet header
        if (rx_lp_av_en_i) begin
            bytes_left <= (rx_dt_i == camera_pkg::DT_RAW8) ? rx_wc_i : 16'd0;
        end else if (take_byte) begin
            bytes_left <= bytes_left - 16'd1;
        end

        line_valid_o <= take_byte;
    end
end

// Pixel data follows the payload byte by one cycle
always_ff @(posedge mipi_byte_clock) begin
    pixel_o <= rx_payload_i;
end

// The receiver never sends payload before frame start or after frame end
payload_in_frame: assert property (
    @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
    rx_payload_en_i |-> frame_valid_o
) else $error("Payload byte outside a frame");

endmodule

/* hw/metering.sv */
`timescale 1ns/1ps
// Brightness metering
// Accumulates sum, count and peak of each cropped frame, publishes them at frame end
module metering #(
    parameter int DIM_WIDTH = 12
) (
    input logic mipi_byte_clock,
    input logic mipi_byte_reset_n,

    input logic frame_valid_i,
    input logic line_valid_i,
    input camera_pkg::pixel_t pixel_i,

    output logic [camera_pkg::SUM_WIDTH-1:0] sum_o,
    output logic [2*DIM_WIDTH-1:0] count_o,
    output camera_pkg::pixel_t peak_o,
    output logic ready_o
);

logic [camera_pkg::SUM_WIDTH-1:0] acc_sum;
logic [2*DIM_WIDTH-1:0] acc_count;
camera_pkg::pixel_t acc_peak;
logic frame_valid_q;
logic frame_start;
logic frame_end;

always_comb begin
    frame_start = frame_valid_i && !frame_valid_q;
    frame_end = !frame_valid_i && frame_valid_q;
end

always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        frame_valid_q <= 1'b0;
        acc_sum <= '0;
        acc_count <= '0;
        acc_peak <= '0;
    end else begin
        frame_valid_q <= frame_valid_i;

        if (frame_start) begin
            acc_sum <= '0;
            acc_count <= '0;
            acc_peak <= '0;
        end else if (line_valid_i) begin
            acc_sum <= acc_sum + camera_pkg::SUM_WIDTH'(pixel_i);
            acc_count <= acc_count + 1'b1;
            if (pixel_i > acc_peak) begin
                acc_peak <= pixel_i; // New maximum
            end
        end
    end
end

// Results hold until the next frame end
always_ff @(posedge mipi_byte_clock or negedge mipi_byte_reset_n) begin
    if (!mipi_byte_reset_n) begin
        sum_o <= '0;
        count_o <= '0;
        peak_o <= '0;
        ready_o <= 1'b0;
    end else begin
        ready_o <= frame_end;
        if (frame_end) begin
            sum_o <= acc_sum;
            count_o <= acc_count;
            peak_o <= acc_peak;
        end
    end
end

endmodule

/* run.sh */
#!/bin/sh
# Compile and run the camera front end testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal --top-module camera_tb -f tb.f

# The simulator status is masked by tee, the log decides
./obj_dir/Vcamera_tb | tee sim.log

if grep -q "Test passed" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed"
    exit 1
fi

/* tb.f */
+incdir+test
hw/camera_pkg.sv
hw/csi2_packet_decoder.sv
hw/crop.sv
hw/metering.sv
hw/camera_registers.sv
hw/camera.sv
test/camera_tb.sv

/* test/camera_tb_tasks.svh */
// Testbench tasks for the camera front end
// AXI4-Lite access, CSI-2 packet generation and the metering reference model

task automatic drive_slot();
    @(posedge mipi_byte_clock);
    #1; // Inputs change just after the edge
endtask

task automatic check_equal(input string name, input logic [31:0] got, input logic [31:0] exp);
    assert (got === exp) else begin
        $display("Error: %s is 0x%h, expected 0x%h", name, got, exp);
        fail_run();
    end
endtask

task automatic axi_write(input logic [4:0] addr, input logic [31:0] data,
                         input logic [1:0] exp_resp);
    drive_slot();
    s_axi_awaddr = addr;
    s_axi_awvalid = 1'b1;
    s_axi_wdata = data;
    s_axi_wstrb = 4'hF;
    s_axi_wvalid = 1'b1;
    s_axi_bready = 1'b0; // Response waits a cycle before bready
    @(negedge mipi_byte_clock);
    while (!(s_axi_awready && s_axi_wready)) @(negedge mipi_byte_clock);
    drive_slot();
    s_axi_awvalid = 1'b0;
    s_axi_wvalid = 1'b0;
    @(negedge mipi_byte_clock);
    while (!s_axi_bvalid) @(negedge mipi_byte_clock);
    check_equal("s_axi_bresp", 32'(s_axi_bresp), 32'(exp_resp));
    drive_slot();
    s_axi_bready = 1'b1;
    drive_slot();
    s_axi_bready = 1'b0;
endtask

task automatic axi_read(input logic [4:0] addr, output logic [31:0] data,
                        output logic [1:0] resp);
    drive_slot();
    s_axi_araddr = addr;
    s_axi_arvalid = 1'b1;
    s_axi_rready = 1'b1;
    @(negedge mipi_byte_clock);
    while (!s_axi_arready) @(negedge mipi_byte_clock);
    drive_slot();
    s_axi_arvalid = 1'b0;
    @(negedge mipi_byte_clock);
    while (!s_axi_rvalid) @(negedge mipi_byte_clock);
    data = s_axi_rdata;
    resp = s_axi_rresp;
    drive_slot();
    s_axi_rready = 1'b0;
endtask

task automatic read_expect(input logic [4:0] addr, input string reg_name,
                           input logic [31:0] exp_data, input logic [1:0] exp_resp);
    logic [31:0] data;
    logic [1:0] resp;
    axi_read(addr, data, resp);
    check_equal({"s_axi_rdata (", reg_name, ")"}, data, exp_data);
    check_equal({"s_axi_rresp (", reg_name, ")"}, 32'(resp), 32'(exp_resp));
endtask

// Response held back by rready low with a second request queued behind it
task automatic stalled_read(input logic [4:0] addr, input int stall, input logic [31:0] exp_data);
    logic [31:0] held;
    drive_slot();
    s_axi_araddr = addr;
    s_axi_arvalid = 1'b1; // Stays high as the second request
    s_axi_rready = 1'b0;
    @(negedge mipi_byte_clock);
    while (!s_axi_arready) @(negedge mipi_byte_clock);
    @(negedge mipi_byte_clock);
    while (!s_axi_rvalid) @(negedge mipi_byte_clock);
    held = s_axi_rdata;
    check_equal("s_axi_rdata", held, exp_data);
    repeat (stall) begin
        @(negedge mipi_byte_clock);
        check_equal("s_axi_rvalid", 32'(s_axi_rvalid), 32'd1);
        check_equal("s_axi_rdata", s_axi_rdata, held);
        check_equal("s_axi_arready", 32'(s_axi_arready), 32'd0);
    end
    drive_slot();
    s_axi_rready = 1'b1;
    drive_slot();
    s_axi_rready = 1'b0;
    @(negedge mipi_byte_clock);
    while (!s_axi_arready) @(negedge mipi_byte_clock);
    drive_slot();
    s_axi_arvalid = 1'b0;
    s_axi_rready = 1'b1;
    @(negedge mipi_byte_clock);
    while (!s_axi_rvalid) @(negedge mipi_byte_clock);
    check_equal("s_axi_rdata", s_axi_rdata, exp_data);
    drive_slot();
    s_axi_rready = 1'b0;
endtask

task automatic fill_random_frame();
    for (int y = 0; y < FRAME_H; y++) begin
        for (int x = 0; x < FRAME_W; x++) begin
            frame_pix[y][x] = camera_pkg::pixel_t'($urandom_range(255));
        end
    end
endtask

task automatic send_short(input logic [5:0] dt);
    drive_slot();
    rx_sp_en = 1'b1;
    rx_dt = dt;
    drive_slot();
    rx_sp_en = 1'b0;
    if (dt == camera_pkg::DT_FRAME_END) begin
        frames_sent++;
    end
endtask

// Long packet header, then one payload byte per cycle
task automatic send_line(input logic [5:0] dt, input int row);
    drive_slot();
    rx_lp_av_en = 1'b1;
    rx_dt = dt;
    rx_wc = 16'(FRAME_W);
    for (int x = 0; x < FRAME_W; x++) begin
        drive_slot();
        rx_lp_av_en = 1'b0;
        rx_payload_en = 1'b1;
        rx_payload = frame_pix[row][x];
    end
    drive_slot();
    rx_payload_en = 1'b0;
endtask

task automatic send_rows(input int first, input int last);
    for (int y = first; y < last; y++) begin
        send_line(camera_pkg::DT_RAW8, y);
    end
endtask

task automatic send_frame();
    send_short(camera_pkg::DT_FRAME_START);
    send_rows(0, FRAME_H);
    send_short(camera_pkg::DT_FRAME_END);
endtask

// Start inclusive, end exclusive
task automatic model_window(input int xs, input int xe, input int ys, input int ye);
    exp_sum = 0;
    exp_count = 0;
    exp_peak = 0;
    for (int y = 0; y < FRAME_H; y++) begin
        for (int x = 0; x < FRAME_W; x++) begin
            if (x >= xs && x < xe && y >= ys && y < ye) begin
                exp_sum = exp_sum + 32'(frame_pix[y][x]);
                exp_count = exp_count + 1;
                if (32'(frame_pix[y][x]) > exp_peak) begin
                    exp_peak = 32'(frame_pix[y][x]);
                end
            end
        end
    end
endtask

task automatic check_results();
    repeat (3) @(posedge mipi_byte_clock); // Frame end to readable results
    read_expect(camera_pkg::REG_SUM, "sum", exp_sum, camera_pkg::RESP_OKAY);
    read_expect(camera_pkg::REG_COUNT, "count", exp_count, camera_pkg::RESP_OKAY);
    read_expect(camera_pkg::REG_PEAK, "peak", exp_peak, camera_pkg::RESP_OKAY);
    read_expect(camera_pkg::REG_FRAMES, "frames", 32'(frames_sent), camera_pkg::RESP_OKAY);
endtask

/* test/camera_tb.sv */
`timescale 1ns/1ps
// Camera front end testbench
// Drives CSI-2 packets and AXI4-Lite accesses and checks results against a window model
module camera_tb;

localparam int DIM_WIDTH = 12;
localparam int FRAME_W = 16;
localparam int FRAME_H = 12;
localparam int NUM_FRAMES = 4;
localparam int NUM_AXI = 48;
localparam logic [5:0] DT_EMBEDDED = 6'h12; // Non-RAW8 long packet type
// A line costs a header, the payload and a gap plus one extra line for the embedded packet
localparam int FRAME_CYCLES = (FRAME_H + 1) * (FRAME_W + 3) + 10;
localparam int WATCHDOG_NS = 20 * (NUM_FRAMES * FRAME_CYCLES + NUM_AXI * 10 + 20);

logic mipi_byte_clock;
logic mipi_byte_reset_n;
logic rx_sp_en;
logic rx_lp_av_en;
logic [5:0] rx_dt;
logic [15:0] rx_wc;
logic rx_payload_en;
camera_pkg::pixel_t rx_payload;
logic [4:0] s_axi_awaddr;
logic s_axi_awvalid;
logic s_axi_awready;
logic [31:0] s_axi_wdata;
logic [3:0] s_axi_wstrb;
logic s_axi_wvalid;
logic s_axi_wready;
logic [1:0] s_axi_bresp;
logic s_axi_bvalid;
logic s_axi_bready;
logic [4:0] s_axi_araddr;
logic s_axi_arvalid;
logic s_axi_arready;
logic [31:0] s_axi_rdata;
logic [1:0] s_axi_rresp;
logic s_axi_rvalid;
logic s_axi_rready;

camera_pkg::pixel_t frame_pix [FRAME_H][FRAME_W];
logic [31:0] exp_sum;
logic [31:0] exp_count;
logic [31:0] exp_peak;
int frames_sent;

camera #(.DIM_WIDTH(DIM_WIDTH)) dut0 (
    .mipi_byte_clock(mipi_byte_clock),
    .mipi_byte_reset_n(mipi_byte_reset_n),
    .rx_sp_en_i(rx_sp_en),
    .rx_lp_av_en_i(rx_lp_av_en),
    .rx_dt_i(rx_dt),
    .rx_wc_i(rx_wc),
    .rx_payload_en_i(rx_payload_en),
    .rx_payload_i(rx_payload),
    .s_axi_awaddr_i(s_axi_awaddr),
    .s_axi_awvalid_i(s_axi_awvalid),
    .s_axi_awready_o(s_axi_awready),
    .s_axi_wdata_i(s_axi_wdata),
    .s_axi_wstrb_i(s_axi_wstrb),
    .s_axi_wvalid_i(s_axi_wvalid),
    .s_axi_wready_o(s_axi_wready),
    .s_axi_bresp_o(s_axi_bresp),
    .s_axi_bvalid_o(s_axi_bvalid),
    .s_axi_bready_i(s_axi_bready),
    .s_axi_araddr_i(s_axi_araddr),
    .s_axi_arvalid_i(s_axi_arvalid),
    .s_axi_arready_o(s_axi_arready),
    .s_axi_rdata_o(s_axi_rdata),
    .s_axi_rresp_o(s_axi_rresp),
    .s_axi_rvalid_o(s_axi_rvalid),
    .s_axi_rready_i(s_axi_rready)
);

always #5 mipi_byte_clock = ~mipi_byte_clock;

task automatic fail_run();
    $display("Test failed");
    $fatal(1, "Stopped at the first error");
endtask

`include "camera_tb_tasks.svh"

read_data_stable: assert property (
    @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
    s_axi_rvalid && !s_axi_rready |=> s_axi_rvalid && $stable(s_axi_rdata)
) else begin
    $display("Read response dropped or changed while rready was low");
    fail_run();
end

// No new read while a response waits
read_blocked: assert property (
    @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
    s_axi_rvalid |-> !s_axi_arready
) else begin
    $display("A read was accepted while a read response was pending");
    fail_run();
end

write_resp_held: assert property (
    @(posedge mipi_byte_clock) disable iff (!mipi_byte_reset_n)
    s_axi_bvalid && !s_axi_bready |=> s_axi_bvalid
) else begin
    $display("Write response dropped before bready");
    fail_run();
end

initial begin
    #(WATCHDOG_NS);
    $display("Timeout, the run did not finish within %0d ns", WATCHDOG_NS);
    fail_run();
end

initial begin
    void'($urandom(24257));
    mipi_byte_clock = 1'b0;
    mipi_byte_reset_n = 1'b0;
    rx_sp_en = 1'b0;
    rx_lp_av_en = 1'b0;
    rx_dt = '0;
    rx_wc = '0;
    rx_payload_en = 1'b0;
    rx_payload = '0;
    s_axi_awaddr = '0;
    s_axi_awvalid = 1'b0;
    s_axi_wdata = '0;
    s_axi_wstrb = '0;
    s_axi_wvalid = 1'b0;
    s_axi_bready = 1'b0;
    s_axi_araddr = '0;
    s_axi_arvalid = 1'b0;
    s_axi_rready = 1'b0;
    frames_sent = 0;
    repeat (5) @(posedge mipi_byte_clock);
    #1;
    mipi_byte_reset_n = 1'b1;

    // Reset values
    read_expect(camera_pkg::REG_X_START, "x_start", 32'd0, camera_pkg::RESP_OKAY);
    read_expect(camera_pkg::REG_X_END, "x_end", 32'((1 << DIM_WIDTH) - 1), camera_pkg::RESP_OKAY);
    read_expect(camera_pkg::REG_Y_START, "y_start", 32'd0, camera_pkg::RESP_OKAY);
    read_expect(camera_pkg::REG_Y_END, "y_end", 32'((1 << DIM_WIDTH) - 1), camera_pkg::RESP_OKAY);
    exp_sum = 0;
    exp_count = 0;
    exp_peak = 0;
    check_results();

    // Window registers, a read-only write and an unmapped offset
    axi_write(camera_pkg::REG_X_START, 32'd3, camera_pkg::RESP_OKAY);
    axi_write(camera_pkg::REG_X_END, 32'd11, camera_pkg::RESP_OKAY);
    axi_write(camera_pkg::REG_Y_START, 32'd2, camera_pkg::RESP_OKAY);
    axi_write(camera_pkg::REG_Y_END, 32'd9, camera_pkg::RESP_OKAY);
    read_expect(camera_pkg::REG_X_START, "x_start", 32'd3, camera_pkg::RESP_OKAY);
    read_expect(camera_pkg::REG_X_END, "x_end", 32'd11, camera_pkg::RESP_OKAY);
    read_expect(camera_pkg::REG_Y_START, "y_start", 32'd2, camera_pkg::RESP_OKAY);
    read_expect(camera_pkg::REG_Y_END, "y_end", 32'd9, camera_pkg::RESP_OKAY);
    axi_write(camera_pkg::REG_SUM, 32'h0ABC_DEF0, camera_pkg::RESP_OKAY);
    read_expect(camera_pkg::REG_SUM, "sum", 32'd0, camera_pkg::RESP_OKAY);
    axi_write(5'h1E, 32'h1234, camera_pkg::RESP_SLVERR);
    read_expect(5'h1E, "unmapped", 32'd0, camera_pkg::RESP_SLVERR);

    // One frame through the window
    fill_random_frame();
    send_frame();
    model_window(3, 11, 2, 9);
    check_results();

    // Window change in mid frame keeps the old window for this frame
    fill_random_frame();
    send_short(camera_pkg::DT_FRAME_START);
    send_rows(0, 5);
    axi_write(camera_pkg::REG_X_START, 32'd5, camera_pkg::RESP_OKAY);
    axi_write(camera_pkg::REG_X_END, 32'd16, camera_pkg::RESP_OKAY);
    axi_write(camera_pkg::REG_Y_START, 32'd4, camera_pkg::RESP_OKAY);
    axi_write(camera_pkg::REG_Y_END, 32'd12, camera_pkg::RESP_OKAY);
    send_rows(5, FRAME_H);
    send_short(camera_pkg::DT_FRAME_END);
    model_window(3, 11, 2, 9);
    check_results();
    fill_random_frame();
    send_frame();
    model_window(5, 16, 4, 12);
    check_results();

    // Embedded data packet between lines leaves the results alone
    fill_random_frame();
    send_short(camera_pkg::DT_FRAME_START);
    send_rows(0, 6);
    send_line(DT_EMBEDDED, 0);
    send_rows(6, FRAME_H);
    send_short(camera_pkg::DT_FRAME_END);
    model_window(5, 16, 4, 12);
    check_results();

    stalled_read(camera_pkg::REG_FRAMES, 6, 32'(frames_sent));

    $display("Test passed");
    $finish;
end

endmodule
